/* Bender.yml */
package:
  name: dmac_read

sources:
  - files:
      - hdl/dmac_cfg_pkg.sv
      - hdl/dmac_cmd_pkg.sv
      - hdl/dmac_cmd_fifo.sv
      - hdl/dmac_burst_splitter.sv
      - hdl/dmac_read_mover.sv
      - hdl/dmac_read_top.sv
  - target: test
    files:
      - dv/dmac_read_chk.sv
      - dv/dmac_read_tb.sv

/* dmac_read_top.f */
hdl/dmac_cfg_pkg.sv
hdl/dmac_cmd_pkg.sv
hdl/dmac_cmd_fifo.sv
hdl/dmac_burst_splitter.sv
hdl/dmac_read_mover.sv
hdl/dmac_read_top.sv
dv/dmac_read_chk.sv
dv/dmac_read_tb.sv

/* dv/dmac_read_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module dmac_read_chk
  import dmac_cmd_pkg::*;
(
  input wire             CLK0,
  input wire             RST0,
  input wire             arvalid,
  input wire             arready,
  input wire ext_addr_t  araddr,
  input wire burst_len_t arlen,
  input wire             req_busy,
  input wire             core_write_enable,
  input wire             core_write_almost_full
);

  int fail_cnt = 0;  // read by the testbench

  // AR payload holds until the slave accepts it
  ar_hold: assert property (@(posedge CLK0) disable iff (RST0)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
    else begin
      fail_cnt++;
      $error("AR address or length moved before arready");
    end

  // a core write belongs to an outstanding request and respects almost-full
  core_room: assert property (@(posedge CLK0) disable iff (RST0)
    core_write_enable |-> req_busy && !core_write_almost_full)
    else begin
      fail_cnt++;
      $error("core write while idle or while the core is almost full");
    end

  rst_ar_quiet: assert property (@(posedge CLK0)
    RST0 |=> !arvalid ##1 !arvalid)  // quiet through reset and one cycle on
    else begin
      fail_cnt++;
      $error("arvalid high around reset");
    end

endmodule

bind dmac_read_top dmac_read_chk u_chk (
  .CLK0                   (CLK0),
  .RST0                   (RST0),
  .arvalid                (arvalid),
  .arready                (arready),
  .araddr                 (araddr),
  .arlen                  (arlen),
  .req_busy               (req_busy),
  .core_write_enable      (core_write_enable),
  .core_write_almost_full (core_write_almost_full)
);

`default_nettype wire

/* dv/dmac_read_input.txt */
// columns: tag address count, all hex
// tag 1 request (byte address, words), tag 2 expected burst (araddr, arlen), tag 0 end
// 4 KB crossing
1 00000FF0 008
2 00000FF0 003
2 00001000 003
// longer than 256 words
1 00002000 12C
2 00002000 0FF
2 00002400 02B
// unaligned address
1 00003107 005
2 00003104 004
// zero size, no burst
1 00005000 000
// crossing with a capped rest
1 00006F00 050
2 00006F00 03F
2 00007000 00F
0 00000000 000

/* dv/dmac_read_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dmac_read_tb
  import dmac_cfg_pkg::*, dmac_cmd_pkg::*;
();

  localparam int    TIMEOUT    = 20000;  // cycles per wait
  localparam int    STIM_DEPTH = 32;     // records
  localparam data_t PATTERN    = 32'hA5A5_0000;

  logic       CLK0;
  logic       RST0;
  logic       req_valid;
  ext_addr_t  req_ext_addr;
  word_size_t req_word_size;
  logic       req_ready;
  logic       req_busy;
  logic       arvalid;
  ext_addr_t  araddr;
  burst_len_t arlen;
  logic       arready;
  logic       rvalid;
  data_t      rdata;
  logic       rready;
  logic       core_write_almost_full;
  logic       core_write_enable;
  data_t      core_write_data;

  // tag, address, count per record
  logic [WORD_SIZE_W-1:0] stim [0:3*STIM_DEPTH-1];

  ext_addr_t  exp_ar_addr [$];
  burst_len_t exp_ar_len  [$];
  data_t      exp_data    [$];
  ext_addr_t  slv_addr    [$];  // bursts accepted by the slave model
  burst_len_t slv_len     [$];

  int          misc_err = 0;
  int          ar_err   = 0;
  int          data_err = 0;
  int          test_cnt = 0;
  int          ar_cnt   = 0;
  longint      beat_cnt = 0;
  logic [31:0] lcg_state;
  logic        rand_on;
  int          ar_wait;
  int          r_left;
  ext_addr_t   r_word;

  dmac_read_top uut (
    .CLK0                   (CLK0),
    .RST0                   (RST0),
    .req_valid              (req_valid),
    .req_ext_addr           (req_ext_addr),
    .req_word_size          (req_word_size),
    .req_ready              (req_ready),
    .req_busy               (req_busy),
    .arvalid                (arvalid),
    .araddr                 (araddr),
    .arlen                  (arlen),
    .arready                (arready),
    .rvalid                 (rvalid),
    .rdata                  (rdata),
    .rready                 (rready),
    .core_write_almost_full (core_write_almost_full),
    .core_write_enable      (core_write_enable),
    .core_write_data        (core_write_data)
  );

  initial begin
    CLK0 = 1'b0;
    forever #50 CLK0 = ~CLK0;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // data the slave returns for a word address
  function automatic data_t word_pattern(input ext_addr_t word_addr);
    return word_addr ^ PATTERN;
  endfunction

  function automatic int total_errors();
    return misc_err + ar_err + data_err + uut.u_chk.fail_cnt;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] got, inout int errs);
    if (got !== exp) begin
      $display("FAIL %s expected %0h got %0h", name, exp, got);
      errs++;
    end
  endtask

  task automatic finish_run();
    $display("tests %0d, errors %0d, assertion failures %0d",
             test_cnt, total_errors(), uut.u_chk.fail_cnt);
    if (total_errors() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    $display("timeout after %0d cycles waiting for %s", TIMEOUT, what);
    misc_err++;
    finish_run();
  endtask

  task automatic test_done(input int num, input string what, input int errs);
    test_cnt++;
    $display("test %0d %s: %0d errors", num, what, errs);
  endtask

  task automatic wait_busy(input logic level);
    int t;
    t = 0;
    @(posedge CLK0);
    while (req_busy !== level) begin
      t++;
      if (t >= TIMEOUT) timed_out(level ? "req_busy to rise" : "req_busy to fall");
      @(posedge CLK0);
    end
  endtask

  task automatic send_request(input ext_addr_t addr, input word_size_t size);
    int t;
    t = 0;
    @(posedge CLK0);
    while (!req_ready) begin  // caller side of the request handshake
      t++;
      if (t >= TIMEOUT) timed_out("req_ready");
      @(posedge CLK0);
    end
    req_valid     <= 1'b1;
    req_ext_addr  <= addr;
    req_word_size <= size;
    @(posedge CLK0);
    req_valid <= 1'b0;
  endtask

  // queue the expected bursts and words first, then drive the requests
  task automatic run_requests(input logic zero_only, output longint words);
    int        i;
    int        w;
    logic      take;
    ext_addr_t base;
    words = 0;
    take  = 1'b0;
    for (i = 0; i < STIM_DEPTH && stim[3*i] != 0; i++) begin
      if (stim[3*i] == 1) begin
        take = !zero_only || (stim[3*i+2] == 0);
        if (take) begin
          words += stim[3*i+2];
          base = stim[3*i+1][EXT_ADDR_W-1:0] >> BYTE_SHIFT;
          for (w = 0; w < int'(stim[3*i+2]); w++) begin
            exp_data.push_back(word_pattern(base + w));
          end
        end
      end else if (stim[3*i] == 2 && take) begin
        exp_ar_addr.push_back(stim[3*i+1][EXT_ADDR_W-1:0]);
        exp_ar_len.push_back(stim[3*i+2][BLEN_W-1:0]);
      end
    end
    for (i = 0; i < STIM_DEPTH && stim[3*i] != 0; i++) begin
      if (stim[3*i] == 1 && (!zero_only || stim[3*i+2] == 0)) begin
        send_request(stim[3*i+1][EXT_ADDR_W-1:0], stim[3*i+2]);
      end
    end
  endtask

  // --------------------------------------------------------------------
  // AXI read slave and core back-pressure
  // --------------------------------------------------------------------
  always @(posedge CLK0) begin
    logic [31:0] r;
    ext_addr_t   w;
    if (RST0) begin
      arready                <= 1'b0;
      rvalid                 <= 1'b0;
      core_write_almost_full <= 1'b0;
      ar_wait                <= 0;
      r_left                 <= 0;
    end else begin
      if (arvalid && arready) begin
        slv_addr.push_back(araddr);
        slv_len.push_back(arlen);
        arready <= 1'b0;
        r = next_rand();
        ar_wait <= rand_on ? int'(r[7:4] % 5) : 0;  // delay of the next burst
      end else if (arvalid) begin
        if (ar_wait == 0) arready <= 1'b1;
        else              ar_wait <= ar_wait - 1;
      end
      if (rvalid && rready) begin
        if (r_left == 1) rvalid <= 1'b0;
        r_word <= r_word + 1;
        r_left <= r_left - 1;
        rdata  <= word_pattern(r_word + 1);
      end else if (!rvalid && r_left == 0 && slv_addr.size() > 0) begin
        w = slv_addr.pop_front() >> BYTE_SHIFT;
        r_left <= int'(slv_len.pop_front()) + 1;
        r_word <= w;
        rdata  <= word_pattern(w);
        rvalid <= 1'b1;
      end
      r = next_rand();
      core_write_almost_full <= rand_on && (r[31:30] == 2'b00);
    end
  end

  // --------------------------------------------------------------------
  // monitors
  // --------------------------------------------------------------------
  always @(posedge CLK0) begin
    if (!RST0 && arvalid && arready) begin
      ar_cnt++;
      if (exp_ar_addr.size() == 0) begin
        $display("AR burst at %h arrived with no burst expected", araddr);
        ar_err++;
      end else begin
        check_value("araddr", exp_ar_addr.pop_front(), araddr, ar_err);
        check_value("arlen", exp_ar_len.pop_front(), arlen, ar_err);
      end
    end
  end

  always @(posedge CLK0) begin
    if (!RST0 && core_write_enable) begin
      beat_cnt++;
      if (exp_data.size() == 0) begin
        $display("core write of %h arrived with no word expected", core_write_data);
        data_err++;
      end else begin
        check_value("core_write_data", exp_data.pop_front(), core_write_data, data_err);
      end
    end
  end

  // --------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------
  initial begin
    int     e0;
    int     ar0;
    longint b0;
    longint words;
    lcg_state              = 32'd29;
    rand_on                = 1'b0;
    RST0                   = 1'b1;
    req_valid              = 1'b0;
    req_ext_addr           = '0;
    req_word_size          = '0;
    arready                = 1'b0;
    rvalid                 = 1'b0;
    rdata                  = '0;
    core_write_almost_full = 1'b0;
    $readmemh("dv/dmac_read_input.txt", stim);
    repeat (3) @(posedge CLK0);
    RST0 <= 1'b0;

    @(posedge CLK0);
    e0 = misc_err;
    check_value("req_ready", 1'b1, req_ready, misc_err);
    check_value("req_busy", 1'b0, req_busy, misc_err);
    check_value("arvalid", 1'b0, arvalid, misc_err);
    check_value("rready", 1'b0, rready, misc_err);
    test_done(1, "reset state", misc_err - e0);

    // bursts and data with a quick slave
    e0 = ar_err;
    b0 = beat_cnt;
    ar0 = data_err;
    run_requests(1'b0, words);
    wait_busy(1'b1);
    wait_busy(1'b0);
    if (exp_ar_addr.size() != 0) begin
      $display("%0d expected AR bursts were never issued", exp_ar_addr.size());
      ar_err++;
    end
    test_done(2, "AR bursts in order", ar_err - e0);
    if (exp_data.size() != 0) begin
      $display("%0d expected words never reached the core", exp_data.size());
      data_err++;
    end
    check_value("beat count", words, beat_cnt - b0, data_err);
    test_done(3, "core write data", data_err - ar0);

    // zero size
    e0 = misc_err;
    ar0 = ar_cnt;
    run_requests(1'b1, words);
    wait_busy(1'b1);
    wait_busy(1'b0);
    check_value("AR burst count", ar0, ar_cnt, misc_err);
    test_done(4, "zero-size request", misc_err - e0);

    // random arready delays and almost-full
    e0 = total_errors();
    b0 = beat_cnt;
    rand_on <= 1'b1;
    run_requests(1'b0, words);
    wait_busy(1'b1);
    wait_busy(1'b0);
    if (exp_ar_addr.size() != 0 || exp_data.size() != 0) begin
      $display("bursts or words still expected after req_busy fell");
      misc_err++;
    end
    check_value("beat count", words, beat_cnt - b0, data_err);
    repeat (50) begin
      @(posedge CLK0);
      check_value("arvalid", 1'b0, arvalid, misc_err);
    end
    test_done(5, "random back-pressure", total_errors() - e0);

    finish_run();
  end

endmodule

`default_nettype wire

/* hdl/dmac_burst_splitter.sv */
`timescale 1ns/1ns
`default_nettype none

module dmac_burst_splitter
  import dmac_cfg_pkg::*, dmac_cmd_pkg::*;
(
  input  wire              CLK0,
  input  wire              RST0,
  // request queue
  input  wire              req_empty,
  input  wire req_cmd_t    req_head,
  output logic             req_deq,
  // issued queue and mover
  input  wire              issued_full,
  input  wire              issued_empty,
  input  wire              mover_active,
  output logic             issued_enq,
  // AR channel
  output logic             arvalid,
  output ext_addr_t        araddr,
  output burst_len_t       arlen,
  input  wire              arready,
  output logic             req_busy
);

  req_state_t state;
  ext_addr_t  cur_addr;       // next burst start, word aligned
  word_size_t cur_size;       // words still to request
  word_size_t rest_for_bound; // words up to the 4 KB page end
  word_size_t size_cap;
  word_size_t burst_beats;
  word_size_t ar_beats;
  ext_addr_t  head_addr;
  word_size_t head_size;
  logic       ar_done;

  assign head_addr = req_head[REQ_CMD_W-1 -: EXT_ADDR_W];
  assign head_size = req_head[WORD_SIZE_W-1:0];

  function automatic ext_addr_t align_word(input ext_addr_t addr);
    align_word = {addr[EXT_ADDR_W-1:BYTE_SHIFT], {BYTE_SHIFT{1'b0}}};
  endfunction

  function automatic word_size_t words_to_bound(input ext_addr_t addr);
    words_to_bound = word_size_t'(1 << (BOUNDARY_W - BYTE_SHIFT))
                   - word_size_t'(addr[BOUNDARY_W-1:BYTE_SHIFT]);
  endfunction

  function automatic word_size_t cap_size(input word_size_t size);
    cap_size = (size <= word_size_t'(MAX_BURST_LEN)) ? size : word_size_t'(MAX_BURST_LEN);
  endfunction

  //----------------------------------------------------------------------
  // handshakes
  //----------------------------------------------------------------------
  assign req_deq     = (state == ST_IDLE) && !req_empty && !issued_full;
  assign ar_done     = (state == ST_WAIT) && arvalid && arready;
  assign issued_enq  = ar_done;  // arlen goes into the issued queue
  assign burst_beats = (size_cap <= rest_for_bound) ? size_cap : rest_for_bound;
  assign ar_beats    = word_size_t'(arlen) + word_size_t'(1);

  //----------------------------------------------------------------------
  // request FSM
  //----------------------------------------------------------------------
  always_ff @(posedge CLK0) begin
    if (RST0) begin
      state   <= ST_IDLE;
      arvalid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_deq) state <= ST_CHECK;
        end
        ST_CHECK: begin  // head entry is valid this cycle
          cur_addr       <= align_word(head_addr);
          cur_size       <= head_size;
          rest_for_bound <= words_to_bound(head_addr);
          size_cap       <= cap_size(head_size);
          if (head_size == '0) state <= ST_IDLE;
          else                 state <= ST_ISSUE;
        end
        ST_ISSUE: begin
          // a full issued queue holds the burst back
          if (!issued_full) begin
            arvalid <= 1'b1;
            araddr  <= cur_addr;
            arlen   <= burst_len_t'(burst_beats - word_size_t'(1));
            state   <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (ar_done) begin
            arvalid  <= 1'b0;
            cur_size <= cur_size - ar_beats;
            cur_addr <= araddr + (ext_addr_t'(ar_beats) << BYTE_SHIFT);
            if (ar_beats == cur_size) state <= ST_IDLE;
            else                      state <= ST_RECHECK;
          end
        end
        ST_RECHECK: begin
          rest_for_bound <= words_to_bound(cur_addr);
          size_cap       <= cap_size(cur_size);
          state          <= ST_ISSUE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // anything queued, in flight or moving
  always_ff @(posedge CLK0) begin
    if (RST0) begin
      req_busy <= 1'b0;
    end else begin
      req_busy <= (state != ST_IDLE) || !req_empty || !issued_empty || mover_active;
    end
  end

endmodule

`default_nettype wire

/* hdl/dmac_cfg_pkg.sv */
`default_nettype none

package dmac_cfg_pkg;

  //----------------------------------------------------------------------
  // bus geometry
  //----------------------------------------------------------------------
  localparam int EXT_ADDR_W  = 32;  // byte address
  localparam int DATA_W      = 32;
  localparam int BYTE_SHIFT  = 2;   // log2 bytes per word
  localparam int WORD_SIZE_W = 33;  // one bit above the address

  //----------------------------------------------------------------------
  // burst limits
  //----------------------------------------------------------------------
  // AXI bursts must not cross a 4 KB page
  localparam int BOUNDARY_W    = 12;
  localparam int MAX_BURST_LEN = 256;
  localparam int BLEN_W        = 8;  // arlen field

  //----------------------------------------------------------------------
  // command queues
  //----------------------------------------------------------------------
  localparam int CMD_FIFO_ADDR_W = 4;  // 16 entries, 15 usable

endpackage

`default_nettype wire

/* hdl/dmac_cmd_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module dmac_cmd_fifo
  import dmac_cfg_pkg::*;
#(
  parameter int DATA_W_ENTRY = 8
) (
  input  wire                     CLK0,
  input  wire                     RST0,
  input  wire                     enq,
  input  wire  [DATA_W_ENTRY-1:0] din,
  output logic                    full,
  output logic                    almost_full,
  input  wire                     deq,
  output logic [DATA_W_ENTRY-1:0] dout,
  output logic                    empty
);

  logic [CMD_FIFO_ADDR_W-1:0] head;
  logic [CMD_FIFO_ADDR_W-1:0] tail;
  logic [CMD_FIFO_ADDR_W-1:0] head_nxt;
  logic [CMD_FIFO_ADDR_W-1:0] tail_nxt;
  logic [CMD_FIFO_ADDR_W-1:0] tail_nxt_p1;
  logic [CMD_FIFO_ADDR_W-1:0] tail_nxt_p2;
  logic [CMD_FIFO_ADDR_W-1:0] rd_addr;
  logic                       do_enq;
  logic                       do_deq;

  logic [DATA_W_ENTRY-1:0] mem [2**CMD_FIFO_ADDR_W];

  assign do_enq = enq && !full;   // writes when full are dropped
  assign do_deq = deq && !empty;

  // pointers wrap by overflow, depth is a power of two
  assign head_nxt    = do_deq ? head + 1'b1 : head;
  assign tail_nxt    = do_enq ? tail + 1'b1 : tail;
  assign tail_nxt_p1 = tail_nxt + 1'b1;
  assign tail_nxt_p2 = tail_nxt + 2'd2;

  //----------------------------------------------------------------------
  // pointers and flags
  //----------------------------------------------------------------------
  always_ff @(posedge CLK0) begin
    if (RST0) begin
      head        <= '0;
      tail        <= '0;
      empty       <= 1'b1;
      full        <= 1'b0;
      almost_full <= 1'b0;
    end else begin
      head        <= head_nxt;
      tail        <= tail_nxt;
      // flags look at the pointers after this edge
      empty       <= (tail_nxt == head_nxt);
      full        <= (tail_nxt_p1 == head_nxt);
      almost_full <= (tail_nxt_p1 == head_nxt) || (tail_nxt_p2 == head_nxt);
    end
  end

  //----------------------------------------------------------------------
  // storage
  //----------------------------------------------------------------------
  always_ff @(posedge CLK0) begin
    if (do_enq) begin
      mem[tail] <= din;
    end
    rd_addr <= head;  // dout shows the entry that was head last cycle
  end

  assign dout = mem[rd_addr];

endmodule

`default_nettype wire

/* hdl/dmac_cmd_pkg.sv */
`default_nettype none

package dmac_cmd_pkg;

  import dmac_cfg_pkg::*;

  typedef logic [EXT_ADDR_W-1:0]  ext_addr_t;
  typedef logic [WORD_SIZE_W-1:0] word_size_t;  // in words
  typedef logic [BLEN_W-1:0]      burst_len_t;  // beats minus one
  typedef logic [DATA_W-1:0]      data_t;

  // queue entries
  localparam int REQ_CMD_W    = EXT_ADDR_W + WORD_SIZE_W;
  localparam int ISSUED_CMD_W = BLEN_W;

  // address in the upper bits, size in the lower
  typedef logic [REQ_CMD_W-1:0]    req_cmd_t;
  typedef logic [ISSUED_CMD_W-1:0] issued_cmd_t;

  // burst splitter
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CHECK,
    ST_ISSUE,
    ST_WAIT,
    ST_RECHECK
  } req_state_t;

endpackage

`default_nettype wire

/* hdl/dmac_read_mover.sv */
`timescale 1ns/1ns
`default_nettype none

module dmac_read_mover
  import dmac_cfg_pkg::*, dmac_cmd_pkg::*;
(
  input  wire              CLK0,
  input  wire              RST0,
  // issued queue
  input  wire              issued_empty,
  input  wire issued_cmd_t issued_head,
  output logic             issued_deq,
  output logic             mover_active,
  // R channel
  input  wire              rvalid,
  input  wire data_t       rdata,
  output logic             rready,
  // core write port
  input  wire              core_write_almost_full,
  output logic             core_write_enable,
  output data_t            core_write_data
);

  logic              busy;
  logic              head_pending;  // deq issued, head shows next cycle
  logic [BLEN_W:0]   beat_cnt;      // up to 256
  logic              beat_acc;

  assign issued_deq   = !issued_empty && !head_pending && !busy;
  assign mover_active = busy || head_pending;

  assign rready            = busy && !core_write_almost_full;
  assign beat_acc          = rvalid && rready;
  assign core_write_enable = beat_acc;
  assign core_write_data   = rdata;

  //----------------------------------------------------------------------
  // beat counting
  //----------------------------------------------------------------------
  always_ff @(posedge CLK0) begin
    if (RST0) begin
      busy         <= 1'b0;
      head_pending <= 1'b0;
    end else begin
      head_pending <= issued_deq;
      if (busy) begin
        if (beat_acc) begin
          beat_cnt <= beat_cnt - 1'b1;
          if (beat_cnt == 1) busy <= 1'b0;  // last beat of the burst
        end
      end else if (head_pending) begin
        busy     <= 1'b1;
        beat_cnt <= {1'b0, issued_head} + 1'b1;  // len + 1
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/dmac_read_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dmac_read_top
  import dmac_cfg_pkg::*, dmac_cmd_pkg::*;
(
  input  wire              CLK0,
  input  wire              RST0,
  // request side
  input  wire              req_valid,
  input  wire ext_addr_t   req_ext_addr,
  input  wire word_size_t  req_word_size,
  output logic             req_ready,
  output logic             req_busy,
  // AR channel
  output logic             arvalid,
  output ext_addr_t        araddr,
  output burst_len_t       arlen,
  input  wire              arready,
  // R channel
  input  wire              rvalid,
  input  wire data_t       rdata,
  output logic             rready,
  // core write port
  input  wire              core_write_almost_full,
  output logic             core_write_enable,
  output data_t            core_write_data
);

  req_cmd_t    req_tail;
  req_cmd_t    req_head;
  logic        req_deq;
  logic        req_empty;
  logic        req_almost_full;

  issued_cmd_t issued_head;
  logic        issued_enq;
  logic        issued_deq;
  logic        issued_full;
  logic        issued_empty;
  logic        mover_active;

  // pack the request, address on top
  assign req_tail[REQ_CMD_W-1 -: EXT_ADDR_W] = req_ext_addr;
  assign req_tail[WORD_SIZE_W-1:0]           = req_word_size;

  // one slot of slack behind req_ready
  assign req_ready = !req_almost_full;

  //----------------------------------------------------------------------
  // queues
  //----------------------------------------------------------------------
  dmac_cmd_fifo #(.DATA_W_ENTRY(REQ_CMD_W)) u_req_fifo (
    .CLK0        (CLK0),
    .RST0        (RST0),
    .enq         (req_valid),
    .din         (req_tail),
    .full        (),
    .almost_full (req_almost_full),
    .deq         (req_deq),
    .dout        (req_head),
    .empty       (req_empty)
  );

  dmac_cmd_fifo #(.DATA_W_ENTRY(ISSUED_CMD_W)) u_issued_fifo (
    .CLK0        (CLK0),
    .RST0        (RST0),
    .enq         (issued_enq),
    .din         (arlen),
    .full        (issued_full),
    .almost_full (),
    .deq         (issued_deq),
    .dout        (issued_head),
    .empty       (issued_empty)
  );

  //----------------------------------------------------------------------
  // control and data path
  //----------------------------------------------------------------------
  dmac_burst_splitter u_splitter (
    .CLK0         (CLK0),
    .RST0         (RST0),
    .req_empty    (req_empty),
    .req_head     (req_head),
    .req_deq      (req_deq),
    .issued_full  (issued_full),
    .issued_empty (issued_empty),
    .mover_active (mover_active),
    .issued_enq   (issued_enq),
    .arvalid      (arvalid),
    .araddr       (araddr),
    .arlen        (arlen),
    .arready      (arready),
    .req_busy     (req_busy)
  );

  dmac_read_mover u_mover (
    .CLK0                   (CLK0),
    .RST0                   (RST0),
    .issued_empty           (issued_empty),
    .issued_head            (issued_head),
    .issued_deq             (issued_deq),
    .mover_active           (mover_active),
    .rvalid                 (rvalid),
    .rdata                  (rdata),
    .rready                 (rready),
    .core_write_almost_full (core_write_almost_full),
    .core_write_enable      (core_write_enable),
    .core_write_data        (core_write_data)
  );

endmodule

`default_nettype wire
